/* source/aggregatorCfgPkg.sv */
package aggregatorCfgPkg;

    // Bot and fold geometry
    localparam int BotBits   = 128;
    localparam int FoldBits  = 32;
    localparam int FoldWords = BotBits / FoldBits;
    localparam int PopBits   = 6;

    // Term is at most 2**FoldBits, so 33 bits used
    localparam int TermBits  = 35;

    // Batch totals, count wraps modulo 2**CountBits
    localparam int CountBits = 10;
    localparam int SumBits   = CountBits + TermBits;

    // Result FIFO sizing
    localparam int FifoDepthLog2    = 4;
    localparam int FifoDepth        = 1 << FifoDepthLog2;
    localparam int AlmostFullMargin = 4;

endpackage

/* source/botTypesPkg.sv */
package botTypesPkg;
    import aggregatorCfgPkg::*;

    // One monotone boolean function as it enters the pipeline
    typedef logic [BotBits-1:0] botT;

    // What the decoder saw on the input in a given cycle
    typedef enum logic [1:0] {
        opIdle            = 2'd0,
        opAccumulate      = 2'd1,
        opAccumulateClose = 2'd2,
        opClose           = 2'd3
    } decodeOpT;

    // Decoder to accumulator, one per cycle
    typedef struct packed {
        decodeOpT           op;
        logic [PopBits-1:0] popCount;
    } decodedBotT;

    // Finished batch record, as stored in the result FIFO
    typedef struct packed {
        logic [SumBits-1:0]   pcoeffSum;
        logic [CountBits-1:0] pcoeffCount;
    } batchResultT;

endpackage

/* source/botDecoder.sv */
`timescale 1ns/1ns

module botDecoder
    import aggregatorCfgPkg::*;
    import botTypesPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       isBotValid,
    input  botT        bot,
    input  logic       lastBotOfBatch,
    output decodedBotT decoded
);

    logic [FoldBits-1:0] foldWord;
    logic [PopBits-1:0]  foldOnes;
    decodeOpT            nextOp;

    // XOR the 32-bit words of the bot together
    always_comb begin
        foldWord = '0;
        for (int w = 0; w < FoldWords; w++) begin
            foldWord = foldWord ^ bot[w*FoldBits +: FoldBits];
        end
    end

    // Ones in the folded word, 0 to 32
    always_comb begin
        foldOnes = '0;
        for (int b = 0; b < FoldBits; b++) begin
            foldOnes = foldOnes + PopBits'(foldWord[b]);
        end
    end

    // Valid and last flags to opcode
    always_comb begin
        unique case ({isBotValid, lastBotOfBatch})
            2'b10: begin
                nextOp = opAccumulate;
            end
            2'b11: begin
                nextOp = opAccumulateClose;
            end
            2'b01: begin
                nextOp = opClose;
            end
            default: begin
                nextOp = opIdle;
            end
        endcase
    end

    // One register stage between input pins and accumulator
    always_ff @(posedge clk) begin
        // Zero popcount on cycles without a bot
        decoded.popCount <= isBotValid ? foldOnes : '0;
        if (rst) begin
            decoded.op <= opIdle;
        end else begin
            decoded.op <= nextOp;
        end
    end

endmodule

/* source/termAccumulator.sv */
`timescale 1ns/1ns

module termAccumulator
    import aggregatorCfgPkg::*;
    import botTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  decodedBotT  decoded,
    output logic        resultValid,
    output batchResultT batchResult
);

    logic [TermBits-1:0]  term;
    logic                 hasBot;
    logic                 isClose;

    // Running totals of the open batch
    logic [SumBits-1:0]   runSum;
    logic [CountBits-1:0] runCount;

    // Totals including this cycle's bot, if any
    logic [SumBits-1:0]   nextSum;
    logic [CountBits-1:0] nextCount;

    // Stand-in coefficient, 2 to the power of the popcount
    assign term = TermBits'(1) << decoded.popCount;

    always_comb begin
        hasBot  = (decoded.op == opAccumulate) || (decoded.op == opAccumulateClose);
        isClose = (decoded.op == opAccumulateClose) || (decoded.op == opClose);
    end

    always_comb begin
        nextSum   = runSum;
        nextCount = runCount;
        if (hasBot) begin
            nextSum   = runSum + SumBits'(term);
            // Wraps at 1024 by width
            nextCount = runCount + CountBits'(1);
        end
    end

    // Control and running totals
    always_ff @(posedge clk) begin
        if (rst) begin
            runSum      <= '0;
            runCount    <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= isClose;
            if (isClose) begin
                // Next cycle already belongs to a fresh batch
                runSum   <= '0;
                runCount <= '0;
            end else begin
                runSum   <= nextSum;
                runCount <= nextCount;
            end
        end
    end

    // Finished record, held until the next close
    always_ff @(posedge clk) begin
        if (isClose) begin
            batchResult.pcoeffSum   <= nextSum;
            batchResult.pcoeffCount <= nextCount;
        end
    end

    // Decoder must never hand over more ones than a fold can hold
    popCountInRange: assert property (
        @(posedge clk) disable iff (rst)
        decoded.popCount <= PopBits'(FoldBits)
    ) else $error("popcount %0d exceeds fold width", decoded.popCount);

endmodule

/* source/resultFifo.sv */
`timescale 1ns/1ns

module resultFifo
    import aggregatorCfgPkg::*;
    import botTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        writeEnable,
    input  batchResultT dataIn,
    output logic        almostFull,
    input  logic        readEnable,
    output batchResultT dataOut,
    output logic        empty
);

    batchResultT fifoMem [FifoDepth];

    logic [FifoDepthLog2-1:0] readPtr;
    logic [FifoDepthLog2-1:0] writePtr;
    logic [FifoDepthLog2:0]   entryCount;

    logic full;
    logic doWrite;
    logic doRead;
    logic nearlyFull;

    assign empty      = (entryCount == '0);
    assign full       = (entryCount == (FifoDepthLog2 + 1)'(FifoDepth));
    assign nearlyFull = (entryCount >= (FifoDepthLog2 + 1)'(FifoDepth - AlmostFullMargin));

    // Grabs while empty are dropped
    assign doRead  = readEnable && !empty;
    // A full FIFO still takes a write when a read frees a slot
    assign doWrite = writeEnable && (!full || doRead);

    // Oldest record sits on the output whenever not empty
    assign dataOut = fifoMem[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            fifoMem[writePtr] <= dataIn;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            readPtr    <= '0;
            writePtr   <= '0;
            entryCount <= '0;
            almostFull <= 1'b0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            unique case ({doWrite, doRead})
                2'b10: begin
                    entryCount <= entryCount + 1'b1;
                end
                2'b01: begin
                    entryCount <= entryCount - 1'b1;
                end
                default: begin
                    entryCount <= entryCount;
                end
            endcase
            // Registered slow-down, lags the count by one cycle
            almostFull <= nearlyFull;
        end
    end

    // Producer ignored slow-down and a record is lost
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        !(writeEnable && full && !doRead)
    ) else $error("result written into a full FIFO");

    countWithinDepth: assert property (
        @(posedge clk) disable iff (rst)
        entryCount <= (FifoDepthLog2 + 1)'(FifoDepth)
    ) else $error("FIFO entry count %0d above depth", entryCount);

endmodule

/* source/aggregatingPipelineTop.sv */
`timescale 1ns/1ns

module aggregatingPipelineTop
    import botTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Producer side
    input  logic        isBotValid,
    input  botT         bot,
    input  logic        lastBotOfBatch,
    output logic        slowDownInput,

    // Consumer side
    input  logic        grabResults,
    output logic        resultsAvailable,
    output batchResultT result
);

    decodedBotT  decoded;
    logic        resultValid;
    batchResultT batchResult;
    logic        fifoEmpty;

    botDecoder decoder0 (
        .clk            (clk),
        .rst            (rst),
        .isBotValid     (isBotValid),
        .bot            (bot),
        .lastBotOfBatch (lastBotOfBatch),
        .decoded        (decoded)
    );

    termAccumulator accumulator0 (
        .clk         (clk),
        .rst         (rst),
        .decoded     (decoded),
        .resultValid (resultValid),
        .batchResult (batchResult)
    );

    // almostFull is already registered inside the FIFO
    resultFifo fifo0 (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (resultValid),
        .dataIn      (batchResult),
        .almostFull  (slowDownInput),
        .readEnable  (grabResults),
        .dataOut     (result),
        .empty       (fifoEmpty)
    );

    assign resultsAvailable = !fifoEmpty;

endmodule

/* testbench/aggregatorTb.sv */
`timescale 1ns/1ns

module aggregatorTb
    import aggregatorCfgPkg::*;
    import botTypesPkg::*;
();

    localparam int ClockPeriod   = 8;
    localparam int ResetCycles   = 4;
    localparam int DrainCycles   = 64;
    localparam int RandomBatches = 6;
    localparam int PressureBots  = 20;

    typedef struct {
        string name;
        botT   bot;
        bit    valid;
        bit    last;
        bit    grab;
    } stimRowT;

    logic        clk;
    logic        rst;
    logic        isBotValid;
    botT         bot;
    logic        lastBotOfBatch;
    logic        slowDownInput;
    logic        grabResults;
    logic        resultsAvailable;
    batchResultT result;

    // Stimulus table and reference model state
    stimRowT              stimTable[$];
    batchResultT          expectedQ[$];
    logic [SumBits-1:0]   modelSum;
    logic [CountBits-1:0] modelCount;
    int                   droppedRows;
    int                   watchdogLimit;
    bit                   tableReady;

    aggregatingPipelineTop dut0 (
        .clk              (clk),
        .rst              (rst),
        .isBotValid       (isBotValid),
        .bot              (bot),
        .lastBotOfBatch   (lastBotOfBatch),
        .slowDownInput    (slowDownInput),
        .grabResults      (grabResults),
        .resultsAvailable (resultsAvailable),
        .result           (result)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // Term for one bot from the parity of each bit position over all four words
    function automatic logic [TermBits-1:0] refTerm(botT b);
        int ones;
        ones = 0;
        for (int i = 0; i < FoldBits; i++) begin
            if (b[i] ^ b[i + FoldBits] ^ b[i + 2 * FoldBits] ^ b[i + 3 * FoldBits]) begin
                ones++;
            end
        end
        return TermBits'(1) << ones;
    endfunction

    function automatic stimRowT makeRow(string name, botT b, bit valid, bit last, bit grab);
        stimRowT row;
        row.name  = name;
        row.bot   = b;
        row.valid = valid;
        row.last  = last;
        row.grab  = grab;
        return row;
    endfunction

    task automatic addRow(string name, botT b, bit valid, bit last, bit grab);
        stimTable.push_back(makeRow(name, b, valid, last, grab));
    endtask

    // Idle cycles that only grab
    task automatic addDrain(string name, int cycles);
        for (int i = 0; i < cycles; i++) begin
            addRow(name, '0, 1'b0, 1'b0, 1'b1);
        end
    endtask

    task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Reference model fed with what the producer really issued
    task automatic modelInput(bit valid, bit last, botT b);
        batchResultT rec;
        if (valid) begin
            modelSum   = modelSum + SumBits'(refTerm(b));
            modelCount = modelCount + 1'b1;
        end
        if (last) begin
            rec.pcoeffSum   = modelSum;
            rec.pcoeffCount = modelCount;
            expectedQ.push_back(rec);
            modelSum   = '0;
            modelCount = '0;
        end
    endtask

    task automatic modelReset();
        expectedQ.delete();
        modelSum   = '0;
        modelCount = '0;
    endtask

    // One table cycle driven on the falling edge
    task automatic applyRow(stimRowT row);
        bit          accepted;
        batchResultT expected;
        @(negedge clk);
        // A grab with data pops the front record on the coming edge
        if (row.grab && resultsAvailable) begin
            checkValue({row.name, " pending"}, 64'(1), 64'(expectedQ.size() != 0));
            expected = expectedQ.pop_front();
            checkValue(row.name, 64'(expected), 64'(result));
        end
        // Producer holds back while slow-down is up
        accepted = !slowDownInput;
        if ((row.valid || row.last) && !accepted) begin
            droppedRows++;
        end
        bot            = row.bot;
        isBotValid     = row.valid && accepted;
        lastBotOfBatch = row.last && accepted;
        grabResults    = row.grab;
        if (accepted) begin
            modelInput(row.valid, row.last, row.bot);
        end
    endtask

    task automatic buildTable();
        int len;

        // Fixed bots whose folds are 0, 0xF, 0, 0xF0 and all ones
        addRow("singleBatch", '0, 1'b1, 1'b0, 1'b0);
        addRow("singleBatch", {96'h0, 32'h0000_000F}, 1'b1, 1'b0, 1'b0);
        addRow("singleBatch", '1, 1'b1, 1'b0, 1'b0);
        addRow("singleBatch", {32'h0000_00FF, 64'h0, 32'h0000_000F}, 1'b1, 1'b0, 1'b0);
        addRow("singleBatch", {96'h0, 32'hFFFF_FFFF}, 1'b1, 1'b1, 1'b0);
        addDrain("singleBatch", 4);

        // Close with nothing open
        addRow("emptyClose", '0, 1'b0, 1'b1, 1'b0);
        addDrain("emptyClose", 4);

        // Invalid cycles carry junk that must not count
        addRow("idleGaps", {96'h0, 32'h0000_0003}, 1'b1, 1'b0, 1'b0);
        addRow("idleGaps", {4{32'hDEAD_BEEF}} ^ 128'h1, 1'b0, 1'b0, 1'b0);
        addRow("idleGaps", '1, 1'b0, 1'b0, 1'b0);
        addRow("idleGaps", {96'h0, 32'h0001_0001}, 1'b1, 1'b1, 1'b0);
        addDrain("idleGaps", 4);

        // Closing bot stays in its batch and the next one opens a new batch
        addRow("boundary", {96'h0, 32'h0000_0007}, 1'b1, 1'b1, 1'b0);
        addRow("boundary", {64'h0, 32'h0000_FFFF, 32'h0}, 1'b1, 1'b0, 1'b0);
        addRow("boundary", {32'h0000_0001, 96'h0}, 1'b1, 1'b1, 1'b0);
        addDrain("boundary", 5);

        for (int b = 0; b < RandomBatches; b++) begin
            len = 1 + int'($urandom_range(19));
            for (int n = 0; n < len; n++) begin
                addRow("randomBatch", {$urandom(), $urandom(), $urandom(), $urandom()},
                       1'b1, n == len - 1, bit'($urandom_range(1)));
            end
        end
        addDrain("randomBatch", 10);

        // One-bot batches with no grabs until slow-down kicks in
        for (int i = 0; i < PressureBots; i++) begin
            addRow("backPressure", {96'h0, 32'(i * 3 + 1)}, 1'b1, 1'b1, 1'b0);
        end
        addDrain("pressureDrain", 24);
        // Grabs on an empty FIFO
        addDrain("emptyGrab", 3);
    endtask

    // Mid-batch reset with the FIFO filled up to its slow-down level
    task automatic runResetTest();
        for (int i = 0; i < FifoDepth - AlmostFullMargin; i++) begin
            applyRow(makeRow("resetHeld", {32'(i + 1), 96'h0}, 1'b1, 1'b1, 1'b0));
        end
        applyRow(makeRow("resetOpen", {96'h0, 32'h0000_0007}, 1'b1, 1'b0, 1'b0));
        applyRow(makeRow("resetOpen", {96'h0, 32'h0000_003F}, 1'b1, 1'b0, 1'b0));
        repeat (4) applyRow(makeRow("resetHeld", '0, 1'b0, 1'b0, 1'b0));
        checkValue("resetHeld available", 64'(1), 64'(resultsAvailable));
        checkValue("resetHeld slowDownInput", 64'(1), 64'(slowDownInput));

        @(negedge clk);
        rst            = 1'b1;
        isBotValid     = 1'b0;
        lastBotOfBatch = 1'b0;
        grabResults    = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        modelReset();
        checkValue("reset resultsAvailable", 64'(0), 64'(resultsAvailable));
        checkValue("reset slowDownInput", 64'(0), 64'(slowDownInput));

        // Count must start again from zero
        applyRow(makeRow("afterReset", {96'h0, 32'h0000_0001}, 1'b1, 1'b1, 1'b0));
        repeat (4) applyRow(makeRow("afterReset", '0, 1'b0, 1'b0, 1'b1));
        checkValue("afterReset drained", 64'(0), 64'(expectedQ.size()));
        checkValue("afterReset resultsAvailable", 64'(0), 64'(resultsAvailable));
    endtask

    initial begin
        wait (tableReady);
        #(watchdogLimit);
        $display("Timeout: run did not finish within %0d ns", watchdogLimit);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst            = 1'b1;
        isBotValid     = 1'b0;
        bot            = '0;
        lastBotOfBatch = 1'b0;
        grabResults    = 1'b0;
        droppedRows    = 0;
        tableReady     = 1'b0;
        modelReset();
        void'($urandom(81));

        buildTable();
        watchdogLimit = (stimTable.size() + DrainCycles) * ClockPeriod * 4;
        tableReady    = 1'b1;

        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;

        foreach (stimTable[i]) begin
            applyRow(stimTable[i]);
        end

        // Everything issued came back in order and the FIFO is idle again
        checkValue("backPressure fired", 64'(1), 64'(droppedRows > 0));
        checkValue("drain queue empty", 64'(0), 64'(expectedQ.size()));
        checkValue("drain resultsAvailable", 64'(0), 64'(resultsAvailable));
        checkValue("drain slowDownInput", 64'(0), 64'(slowDownInput));

        runResetTest();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* compile.f */
source/aggregatorCfgPkg.sv
source/botTypesPkg.sv
source/botDecoder.sv
source/termAccumulator.sv
source/resultFifo.sv
source/aggregatingPipelineTop.sv
testbench/aggregatorTb.sv

/* runSim.sh */
#!/bin/sh
# Build the aggregator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module aggregatorTb \
    -o aggregatorSim > sim.log 2>&1 \
    && ./obj_dir/aggregatorSim >> sim.log 2>&1 \
    || echo ">>> FAIL" >> sim.log

cat sim.log
# Any error or timeout leaves the fail message in the log
if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0
